// ==== build.f ====
hw/touch_pkg.sv
hw/quarter_tick_divider.sv
hw/i2c_touch_reader.sv
hw/hex_display.sv
hw/board_top.sv
tests/touch_controller_model.sv
tests/board_top_tb.sv

// ==== Makefile ====
TOP := board_top_tb

all: run

# build, run, and pass only when the pass line shows up
run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only -Wall --top-module board_top hw/touch_pkg.sv \
	  hw/quarter_tick_divider.sv hw/i2c_touch_reader.sv hw/hex_display.sv hw/board_top.sv

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== tests/board_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;

  logic            hwclk;
  logic            reset;
  // touch pending on pb[1]
  logic            touch;
  logic            sda_level;
  logic [20:0]     pb;
  logic [7:0]      left;
  logic [7:0]      right;
  logic [7:0]      ss7;
  logic [7:0]      ss6;
  logic [7:0]      ss5;
  logic [7:0]      ss4;
  logic [7:0]      ss3;
  logic [7:0]      ss2;
  logic [7:0]      ss1;
  logic [7:0]      ss0;
  logic [7:0][7:0] ss_pins;
  logic [31:0]     report_word;
  logic            nack_address;
  int              start_count;
  int              stop_count;
  logic [7:0]      addr_byte;
  logic            bad_addr;
  logic            bad_ack;
  logic            missing_stop;
  integer          seed;
  int              error_count;
  int              test_errors;
  int              test_count;
  int              failed_tests;
  int              stops_before;
  // what the display should hold now
  logic [31:0]     shown;
  // own glyph table with segment a in bit 0
  logic [6:0]      glyph_table [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  // sda bus level back on pb[20]
  assign pb      = {sda_level, 18'd0, touch, 1'b0};
  assign ss_pins = {ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0};

  board_top board_top_i (
    .hwclk (hwclk),
    .reset (reset),
    .pb    (pb),
    .left  (left),
    .right (right),
    .ss7   (ss7),
    .ss6   (ss6),
    .ss5   (ss5),
    .ss4   (ss4),
    .ss3   (ss3),
    .ss2   (ss2),
    .ss1   (ss1),
    .ss0   (ss0)
  );

  touch_controller_model controller_i (
    .reset        (reset),
    .scl_pin      (left[1]),
    .sda_pin      (left[0]),
    .report       (report_word),
    .nack_address (nack_address),
    .sda_level    (sda_level),
    .start_count  (start_count),
    .stop_count   (stop_count),
    .addr_byte    (addr_byte),
    .bad_addr     (bad_addr),
    .bad_ack      (bad_ack),
    .missing_stop (missing_stop)
  );

  initial begin
    hwclk = 1'b0;
    forever begin
      #50 hwclk = ~hwclk;
    end
  end

  // six reads of fifty scl periods at most
  initial begin
    repeat (6 * 50 * 4 * touch_pkg::div_count) @(posedge hwclk);
    $display("timeout: the run did not finish in the expected time");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected 0x%0h got 0x%0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      error_count++;
    end
  endtask

  // ss7 carries the top nibble
  // decimal point stays dark
  task automatic check_digits(input logic [31:0] value);
    for (int i = 0; i < 8; i++) begin
      compare_value($sformatf("ss%0d", i), {25'd0, glyph_table[value[4 * i +: 4]]},
                    32'(ss_pins[i]));
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == test_errors) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: failed", test_count, name);
    end
    test_errors = error_count;
  endtask

  // hold the interrupt until the bus shows a start
  task automatic press_touch();
    int starts;
    int cycles;
    starts = start_count;
    cycles = 0;
    touch  = 1'b1;
    while (start_count == starts && cycles < 8 * touch_pkg::div_count) begin
      @(negedge hwclk);
      cycles++;
    end
    touch = 1'b0;
    require(start_count != starts, "no START on the bus after the touch interrupt");
    compare_value("left[7]", 32'h0, 32'(left[7]));
  endtask

  task automatic wait_for_end(input logic want_error);
    int cycles;
    cycles = 0;
    while ((want_error ? right[3] : left[7]) !== 1'b1 &&
           cycles < 50 * 4 * touch_pkg::div_count) begin
      @(negedge hwclk);
      cycles++;
    end
    require((want_error ? right[3] : left[7]) === 1'b1,
            "the read did not finish with the expected done or error flag");
  endtask

  task automatic check_protocol(input int stops);
    compare_value("stop_count", stops + 1, stop_count);
    compare_value("left[6:3]", 32'h0, 32'(left[6:3]));
    // spare led bits stay dark
    compare_value("left[2]", 32'h0, 32'(left[2]));
    compare_value("right[7:4]", 32'h0, 32'(right[7:4]));
    compare_value("right[2:0]", 32'h0, 32'(right[2:0]));
    compare_value("addr_byte", 32'h71, 32'(addr_byte));
    require(!bad_addr, "the address byte on the bus was not a read of 0x38");
    require(!bad_ack, "master ACK and NACK on the report bytes were wrong");
    require(!missing_stop, "the transaction was not closed by a STOP");
  endtask

  task automatic good_read(input logic [31:0] value);
    report_word  = value;
    nack_address = 1'b0;
    press_touch();
    wait_for_end(1'b0);
    compare_value("right[3]", 32'h0, 32'(right[3]));
    // digits follow one cycle after done
    check_digits(shown);
    @(negedge hwclk);
    check_digits(value);
    shown = value;
  endtask

  task automatic refused_read();
    report_word  = $random(seed);
    nack_address = 1'b1;
    press_touch();
    wait_for_end(1'b1);
    compare_value("left[7]", 32'h0, 32'(left[7]));
    @(negedge hwclk);
    check_digits(shown);
    nack_address = 1'b0;
  endtask

  initial begin
    seed         = 32'h27ee;
    error_count  = 0;
    test_errors  = 0;
    test_count   = 0;
    failed_tests = 0;
    shown        = '0;
    reset        = 1'b1;
    touch        = 1'b0;
    report_word  = '0;
    nack_address = 1'b0;
    repeat (2) @(negedge hwclk);
    reset = 1'b0;
    @(negedge hwclk);
    // released lines and clear flags
    compare_value("left[1:0]", 32'h0, 32'(left[1:0]));
    compare_value("left[7]", 32'h0, 32'(left[7]));
    compare_value("left[6:3]", 32'h0, 32'(left[6:3]));
    compare_value("right[3]", 32'h0, 32'(right[3]));
    // all digits show 0
    check_digits(32'h0);
    end_test("reset values");
    stops_before = stop_count;
    good_read($random(seed));
    end_test("first touch read");
    check_protocol(stops_before);
    end_test("bus protocol");
    stops_before = stop_count;
    good_read($random(seed));
    check_protocol(stops_before);
    end_test("second touch read");
    // error is sticky until the next good read
    stops_before = stop_count;
    refused_read();
    check_protocol(stops_before);
    stops_before = stop_count;
    good_read($random(seed));
    check_protocol(stops_before);
    end_test("address nack and recovery");
    $display("%0d tests run, %0d failed, %0d check errors", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/touch_controller_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module touch_controller_model (
  input  logic        reset,
  input  logic        scl_pin,
  input  logic        sda_pin,
  input  logic [31:0] report,
  input  logic        nack_address,
  output logic        sda_level,
  output int          start_count,
  output int          stop_count,
  output logic [7:0]  addr_byte,
  output logic        bad_addr,
  output logic        bad_ack,
  output logic        missing_stop
);

  typedef enum logic [1:0] {bus_idle, bus_addr, bus_data, bus_wait_stop} mode_t;

  // a 1 on a pin pulls the line low
  logic       scl;
  // our own pull-down on sda
  logic       pull;
  mode_t      mode;
  // -1 until scl falls after start, 8 is the ack clock
  int         bit_cnt;
  int         byte_idx;
  logic [7:0] rx;

  assign scl       = ~scl_pin;
  assign sda_level = ~sda_pin & ~pull;

  // report bit k of byte b, first byte is the top of the word
  function automatic logic data_bit(input int b, input int k);
    return report[31 - 8 * b - k];
  endfunction

  initial begin
    pull         = 1'b0;
    mode         = bus_idle;
    bit_cnt      = -1;
    byte_idx     = 0;
    rx           = '0;
    start_count  = 0;
    stop_count   = 0;
    addr_byte    = '0;
    bad_addr     = 1'b0;
    bad_ack      = 1'b0;
    missing_stop = 1'b0;
  end

  // start condition
  always @(negedge sda_level) begin
    if (!reset && scl === 1'b1) begin
      if (mode == bus_wait_stop) begin
        missing_stop = 1'b1;
      end
      start_count++;
      mode    = bus_addr;
      bit_cnt = -1;
      rx      = '0;
      pull    = 1'b0;
    end
  end

  // stop condition
  always @(posedge sda_level) begin
    if (!reset && scl === 1'b1) begin
      stop_count++;
      mode = bus_idle;
      pull = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (!reset) begin
      if (mode == bus_addr && bit_cnt >= 0 && bit_cnt < 8) begin
        rx = {rx[6:0], sda_level};
      end
      // master acks bytes 1 to 3 low, nacks the last one high
      if (mode == bus_data && bit_cnt == 8) begin
        if (sda_level !== (byte_idx == touch_pkg::report_bytes - 1)) begin
          bad_ack = 1'b1;
        end
      end
    end
  end

  // all our sda changes happen while scl is low
  always @(negedge scl) begin
    if (!reset) begin
      case (mode)
        bus_addr: begin
          if (bit_cnt == 7) begin
            addr_byte = rx;
            bad_addr  = bad_addr | (rx != {touch_pkg::touch_addr, 1'b1});
            pull      = !nack_address;
            bit_cnt   = 8;
          end else if (bit_cnt == 8) begin
            if (!nack_address) begin
              mode     = bus_data;
              byte_idx = 0;
              bit_cnt  = 0;
              pull     = !data_bit(0, 0);
            end else begin
              mode = bus_wait_stop;
              pull = 1'b0;
            end
          end else begin
            bit_cnt++;
          end
        end
        bus_data: begin
          if (bit_cnt < 7) begin
            bit_cnt++;
            pull = !data_bit(byte_idx, bit_cnt);
          end else if (bit_cnt == 7) begin
            // master owns sda on the ack clock
            pull    = 1'b0;
            bit_cnt = 8;
          end else if (byte_idx == touch_pkg::report_bytes - 1) begin
            mode = bus_wait_stop;
          end else begin
            byte_idx++;
            bit_cnt = 0;
            pull    = !data_bit(byte_idx, 0);
          end
        end
        // another clock instead of stop
        bus_wait_stop: missing_stop = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top (
  input  logic        hwclk,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7,
  output logic [7:0]  ss6,
  output logic [7:0]  ss5,
  output logic [7:0]  ss4,
  output logic [7:0]  ss3,
  output logic [7:0]  ss2,
  output logic [7:0]  ss1,
  output logic [7:0]  ss0
);

  logic                     qtick;
  logic                     int_n;
  logic                     sda_in;
  logic                     scl_out;
  logic                     sda_out;
  logic [31:0]              report;
  logic                     report_valid;
  logic                     done;
  logic                     error;
  touch_pkg::reader_state_t reader_state;
  logic [6:0]               seg7;
  logic [6:0]               seg6;
  logic [6:0]               seg5;
  logic [6:0]               seg4;
  logic [6:0]               seg3;
  logic [6:0]               seg2;
  logic [6:0]               seg1;
  logic [6:0]               seg0;

  // pb[1] high means touch pending, reader wants active low
  assign int_n  = ~pb[1];
  // bus level comes back uninverted
  assign sda_in = pb[20];

  quarter_tick_divider quarter_tick_divider_i (
    .hwclk (hwclk),
    .reset (reset),
    .qtick (qtick)
  );

  i2c_touch_reader i2c_touch_reader_i (
    .hwclk        (hwclk),
    .reset        (reset),
    .qtick        (qtick),
    .int_n        (int_n),
    .sda_in       (sda_in),
    .scl_out      (scl_out),
    .sda_out      (sda_out),
    .report       (report),
    .report_valid (report_valid),
    .done         (done),
    .error        (error),
    .state        (reader_state)
  );

  hex_display hex_display_i (
    .hwclk        (hwclk),
    .reset        (reset),
    .report_valid (report_valid),
    .report       (report),
    .seg7         (seg7),
    .seg6         (seg6),
    .seg5         (seg5),
    .seg4         (seg4),
    .seg3         (seg3),
    .seg2         (seg2),
    .seg1         (seg1),
    .seg0         (seg0)
  );

  // open-drain fets, a 1 on the pin pulls the line low
  // left[7] done, left[6:3] fsm state, left[1] scl, left[0] sda
  assign left  = {done, reader_state, 1'b0, ~scl_out, ~sda_out};
  // right[3] error flag
  assign right = {4'b0000, error, 3'b000};

  // decimal points stay dark
  assign ss7 = {1'b0, seg7};
  assign ss6 = {1'b0, seg6};
  assign ss5 = {1'b0, seg5};
  assign ss4 = {1'b0, seg4};
  assign ss3 = {1'b0, seg3};
  assign ss2 = {1'b0, seg2};
  assign ss1 = {1'b0, seg1};
  assign ss0 = {1'b0, seg0};

endmodule

`default_nettype wire

// ==== hw/hex_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_display (
  input  logic        hwclk,
  input  logic        reset,
  input  logic        report_valid,
  input  logic [31:0] report,
  output logic [6:0]  seg7,
  output logic [6:0]  seg6,
  output logic [6:0]  seg5,
  output logic [6:0]  seg4,
  output logic [6:0]  seg3,
  output logic [6:0]  seg2,
  output logic [6:0]  seg1,
  output logic [6:0]  seg0
);

  // last published report
  logic [31:0]      shown_q;
  // value the digits show from the next edge on
  logic [31:0]      shown_next;
  // digit 0 is the low nibble
  logic [7:0][6:0]  seg_q;

  assign shown_next = report_valid ? report : shown_q;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      shown_q <= '0;
      for (int i = 0; i < 8; i++) begin
        seg_q[i] <= touch_pkg::seg_glyph[0];
      end
    end else begin
      shown_q <= shown_next;
      // refresh every cycle, pins only move on a new report
      for (int i = 0; i < 8; i++) begin
        seg_q[i] <= touch_pkg::seg_glyph[shown_next[4*i +: 4]];
      end
    end
  end

  assign seg7 = seg_q[7];
  assign seg6 = seg_q[6];
  assign seg5 = seg_q[5];
  assign seg4 = seg_q[4];
  assign seg3 = seg_q[3];
  assign seg2 = seg_q[2];
  assign seg1 = seg_q[1];
  assign seg0 = seg_q[0];

endmodule

`default_nettype wire

// ==== hw/i2c_touch_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_touch_reader (
  input  logic                     hwclk,
  input  logic                     reset,
  input  logic                     qtick,
  input  logic                     int_n,
  input  logic                     sda_in,
  output logic                     scl_out,
  output logic                     sda_out,
  output logic [31:0]              report,
  output logic                     report_valid,
  output logic                     done,
  output logic                     error,
  output touch_pkg::reader_state_t state
);

  // interrupt synchronizer, idles high
  logic [1:0]  int_sync;
  // quarter within the current bit
  logic [1:0]  phase;
  logic [2:0]  bit_cnt;
  logic [2:0]  bit_next;
  logic [1:0]  byte_cnt;
  logic        last_byte;
  // target left sda high on the ack clock
  logic        addr_nack;
  // address byte as sent, read bit last
  logic [7:0]  addr_byte;
  // report bytes shift in here, first byte ends at the top
  logic [31:0] shift_reg;
  // states with a full scl pulse per bit
  logic        clocked_bit;
  logic        sample_bit;
  logic        publish;

  assign addr_byte = {touch_pkg::touch_addr, 1'b1};
  assign bit_next  = bit_cnt + 3'd1;
  assign last_byte = (byte_cnt == 2'(touch_pkg::report_bytes - 1));

  assign clocked_bit = (state == touch_pkg::st_addr) ||
                       (state == touch_pkg::st_addr_ack) ||
                       (state == touch_pkg::st_read) ||
                       (state == touch_pkg::st_master_ack);

  // mid-high sample point of a data bit
  assign sample_bit = qtick && (state == touch_pkg::st_read) && (phase == 2'd1);
  // clean stop finished
  assign publish    = qtick && (state == touch_pkg::st_stop) && (phase == 2'd3);

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      int_sync <= 2'b11;
    end else begin
      int_sync <= {int_sync[0], int_n};
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state        <= touch_pkg::st_idle;
      phase        <= '0;
      bit_cnt      <= '0;
      byte_cnt     <= '0;
      addr_nack    <= 1'b0;
      scl_out      <= 1'b1;
      sda_out      <= 1'b1;
      report_valid <= 1'b0;
      done         <= 1'b0;
      error        <= 1'b0;
    end else begin
      report_valid <= 1'b0;
      if (qtick) begin
        phase <= phase + 2'd1;
        // scl rises in quarter 0 and falls in quarter 2 of each bit
        if (clocked_bit && phase == 2'd0) begin
          scl_out <= 1'b1;
        end
        if (clocked_bit && phase == 2'd2) begin
          scl_out <= 1'b0;
        end
        case (state)
          touch_pkg::st_idle: begin
            phase   <= '0;
            scl_out <= 1'b1;
            sda_out <= 1'b1;
            // pending touch starts a read, done drops here
            if (!int_sync[1]) begin
              state <= touch_pkg::st_start;
              done  <= 1'b0;
            end
          end
          touch_pkg::st_start: begin
            // sda falls with scl high, then scl falls
            if (phase == 2'd0) begin
              sda_out <= 1'b0;
            end
            if (phase == 2'd2) begin
              scl_out <= 1'b0;
            end
            if (phase == 2'd3) begin
              sda_out <= addr_byte[7];
              bit_cnt <= '0;
              state   <= touch_pkg::st_addr;
            end
          end
          touch_pkg::st_addr: begin
            // next bit goes out a quarter after scl falls
            if (phase == 2'd3) begin
              if (bit_cnt == 3'd7) begin
                sda_out <= 1'b1;
                state   <= touch_pkg::st_addr_ack;
              end else begin
                bit_cnt <= bit_next;
                sda_out <= addr_byte[~bit_next];
              end
            end
          end
          touch_pkg::st_addr_ack: begin
            if (phase == 2'd1) begin
              addr_nack <= sda_in;
            end
            if (phase == 2'd3) begin
              if (addr_nack) begin
                // hold sda low so stop can release it
                sda_out <= 1'b0;
                state   <= touch_pkg::st_nack_stop;
              end else begin
                sda_out  <= 1'b1;
                bit_cnt  <= '0;
                byte_cnt <= '0;
                state    <= touch_pkg::st_read;
              end
            end
          end
          touch_pkg::st_read: begin
            if (phase == 2'd3) begin
              if (bit_cnt == 3'd7) begin
                // ack all but the last byte
                sda_out <= last_byte;
                state   <= touch_pkg::st_master_ack;
              end else begin
                bit_cnt <= bit_next;
              end
            end
          end
          touch_pkg::st_master_ack: begin
            if (phase == 2'd3) begin
              if (last_byte) begin
                sda_out <= 1'b0;
                state   <= touch_pkg::st_stop;
              end else begin
                sda_out  <= 1'b1;
                bit_cnt  <= '0;
                byte_cnt <= byte_cnt + 2'd1;
                state    <= touch_pkg::st_read;
              end
            end
          end
          touch_pkg::st_stop, touch_pkg::st_nack_stop: begin
            // scl up first, then sda rises while scl is high
            if (phase == 2'd0) begin
              scl_out <= 1'b1;
            end
            if (phase == 2'd1) begin
              sda_out <= 1'b1;
            end
            if (phase == 2'd3) begin
              state <= touch_pkg::st_idle;
              if (state == touch_pkg::st_stop) begin
                report_valid <= 1'b1;
                done         <= 1'b1;
                error        <= 1'b0;
              end else begin
                // sticky until a good read
                error <= 1'b1;
              end
            end
          end
          default: begin
            state <= touch_pkg::st_idle;
          end
        endcase
      end
    end
  end

  // payload path
  always_ff @(posedge hwclk) begin
    if (sample_bit) begin
      shift_reg <= {shift_reg[30:0], sda_in};
    end
    if (publish) begin
      report <= shift_reg;
    end
  end

endmodule

`default_nettype wire

// ==== hw/quarter_tick_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module quarter_tick_divider (
  input  logic hwclk,
  input  logic reset,
  output logic qtick
);

  // free-running period counter
  logic [7:0] count;
  // last cycle of the period
  logic       wrap;

  assign wrap = (count == 8'(touch_pkg::div_count - 1));

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      count <= '0;
      qtick <= 1'b0;
    end else begin
      // one hwclk-wide enable per period
      qtick <= wrap;
      if (wrap) begin
        count <= '0;
      end else begin
        count <= count + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/touch_pkg.sv ====
`default_nettype none

package touch_pkg;

  // hwclk cycles per quarter-bit tick
  // four ticks make one scl period
  localparam int div_count = 252;

  // 7-bit target address of the touch controller
  localparam logic [6:0] touch_addr = 7'h38;

  // bytes in one touch report
  localparam int report_bytes = 4;

  // reader fsm encoding, shown on the left leds
  typedef enum logic [3:0] {
    st_idle       = 4'd0,
    st_start      = 4'd1,
    st_addr       = 4'd2,
    st_addr_ack   = 4'd3,
    st_read       = 4'd4,
    st_master_ack = 4'd5,
    st_stop       = 4'd6,
    st_nack_stop  = 4'd7
  } reader_state_t;

  // active-high segments, bit 0 is segment a, bit 6 is segment g
  // index is the hex digit value
  localparam logic [6:0] seg_glyph [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f,
    7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c,
    7'h39, 7'h5e, 7'h79, 7'h71
  };

endpackage

`default_nettype wire
